//--- hw/spi_link_pkg.sv
`default_nettype none

package spi_link_pkg;

   // frame geometry
   localparam int frame_bits = 32;
   localparam int sync_stages = 2;

   // receive buffer between link and engine
   localparam int fifo_depth = 4;
   localparam int fifo_ptr_bits = $clog2(fifo_depth);

   typedef logic [frame_bits-1:0] word_t;

   // one extra bit so an overlong frame saturates above frame_bits
   typedef logic [$clog2(frame_bits):0] bit_cnt_t;

   // completed frame from the link, valid for one clk
   typedef struct packed {
      logic  valid;
      word_t word;
   } rx_word_t;

   // head of the FIFO, word holds while not_empty is high
   typedef struct packed {
      logic  not_empty;
      word_t word;
   } pop_word_t;

endpackage

`default_nettype wire

//--- hw/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

   typedef enum logic [7:0] {
      nop     = 8'd0,
      init    = 8'd1,
      wr_inv  = 8'd2,
      rd_inv  = 8'd3,
      wr_leds = 8'd4,
      rd_leds = 8'd5,
      wr_vec  = 8'd6,
      rd_vec  = 8'd7
   } opcode_t;

   // elements per vector transfer
   localparam int vec_len = 4;

   typedef logic [$clog2(vec_len)-1:0] vec_idx_t;
   typedef logic [$clog2(vec_len):0] vec_cnt_t;

   typedef struct packed {
      opcode_t     opcode;
      logic [23:0] payload;
   } cmd_view_t;

   typedef struct packed {
      logic [7:0]  unused;
      logic [23:0] data;
   } elem_view_t;

   // same frame, read as a command or as a vector element
   typedef union packed {
      cmd_view_t  cmd;
      elem_view_t elem;
   } cmd_word_u;

   // response for the next frame, load is a one clk strobe
   typedef struct packed {
      logic                load;
      spi_link_pkg::word_t word;
   } resp_t;

endpackage

`default_nettype wire

//--- hw/spi_link.sv
`timescale 1ns/1ps
`default_nettype none

module spi_link
   import spi_link_pkg::*, cmd_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     sck,
   input  logic     ss_n,
   input  logic     mosi,
   output logic     miso,
   output rx_word_t rx,
   output logic     frame_done,
   input  resp_t    resp
);

   logic [sync_stages-1:0] sck_sync;
   logic [sync_stages-1:0] ss_sync;
   logic [sync_stages-1:0] mosi_sync;
   logic sck_d;
   logic ss_d;
   logic sck_s;
   logic ss_s;
   logic mosi_s;
   logic sck_rise;
   logic sck_fall;
   logic ss_rise;
   logic ss_fall;

   bit_cnt_t bit_cnt;
   word_t    rx_shift;
   word_t    rx_word_q;
   word_t    tx_shift;
   word_t    tx_reg;
   logic     valid_q;
   logic     done_q;

   // pin synchronizers, select idles high
   always_ff @(posedge clk) begin
      if (reset) begin
         sck_sync  <= '0;
         ss_sync   <= '1;
         mosi_sync <= '0;
         sck_d     <= 1'b0;
         ss_d      <= 1'b1;
      end else begin
         sck_sync  <= {sck_sync[sync_stages-2:0], sck};
         ss_sync   <= {ss_sync[sync_stages-2:0], ss_n};
         mosi_sync <= {mosi_sync[sync_stages-2:0], mosi};
         sck_d     <= sck_s;
         ss_d      <= ss_s;
      end
   end

   assign sck_s  = sck_sync[sync_stages-1];
   assign ss_s   = ss_sync[sync_stages-1];
   assign mosi_s = mosi_sync[sync_stages-1];

   assign sck_rise = sck_s & ~sck_d;
   assign sck_fall = ~sck_s & sck_d;
   assign ss_rise  = ss_s & ~ss_d;
   assign ss_fall  = ~ss_s & ss_d;

   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt  <= '0;
         tx_shift <= '0;
         tx_reg   <= '0;
         valid_q  <= 1'b0;
         done_q   <= 1'b0;
      end else begin
         valid_q <= 1'b0;
         done_q  <= 1'b0;
         if (ss_fall) begin
            // start of frame, hand the pending response to the shifter
            tx_shift <= tx_reg;
            tx_reg   <= '0;
            bit_cnt  <= '0;
         end else if (!ss_s) begin
            if (sck_rise && bit_cnt != '1) begin
               bit_cnt <= bit_cnt + 1'b1;
            end
            // mode 0, next bit goes out on the falling edge
            if (sck_fall) begin
               tx_shift <= {tx_shift[frame_bits-2:0], 1'b0};
            end
         end
         if (ss_rise) begin
            done_q  <= 1'b1;
            valid_q <= (bit_cnt == bit_cnt_t'(frame_bits));
         end
         // a late load still lands in the register for the next frame
         if (resp.load) begin
            tx_reg <= resp.word;
         end
      end
   end

   // receive data path
   always_ff @(posedge clk) begin
      if (!ss_s && sck_rise) begin
         rx_shift <= {rx_shift[frame_bits-2:0], mosi_s};
      end
      if (ss_rise) begin
         rx_word_q <= rx_shift;
      end
   end

   assign miso       = tx_shift[frame_bits-1];
   assign frame_done = done_q;
   assign rx         = '{valid: valid_q, word: rx_word_q};

endmodule

`default_nettype wire

//--- hw/word_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module word_fifo
   import spi_link_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  rx_word_t  wr,
   output pop_word_t rd,
   input  logic      pop
);

   word_t mem [fifo_depth];

   logic [fifo_ptr_bits-1:0] wr_ptr;
   logic [fifo_ptr_bits-1:0] rd_ptr;
   logic [fifo_ptr_bits:0]   count;
   logic push_ok;
   logic pop_ok;

   assign push_ok = wr.valid && (count != (fifo_ptr_bits+1)'(fifo_depth));
   assign pop_ok  = pop && (count != '0);

   always_ff @(posedge clk) begin
      if (push_ok) begin
         mem[wr_ptr] <= wr.word;
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push_ok, pop_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign rd = '{not_empty: (count != '0), word: mem[rd_ptr]};

endmodule

`default_nettype wire

//--- hw/cmd_engine.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_engine
   import spi_link_pkg::*, cmd_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  pop_word_t   rd,
   output logic        pop,
   input  logic        frame_done,
   output resp_t       resp,
   output logic [15:0] leds
);

   cmd_word_u   w;
   vec_cnt_t    wr_left;
   vec_cnt_t    rd_left;
   vec_idx_t    wr_idx;
   vec_idx_t    rd_idx;
   logic [15:0] inv_reg;
   logic [23:0] vec [vec_len];
   logic        is_cmd;

   // every word is taken as soon as it shows up
   assign pop = rd.not_empty;
   assign w   = rd.word;

   // while a vector write runs, frames are raw elements
   assign is_cmd = (wr_left == '0);
   assign wr_idx = vec_idx_t'(vec_len - wr_left);
   assign rd_idx = vec_idx_t'(vec_len - rd_left);

   always_comb begin
      resp.load = 1'b0;
      resp.word = '0;
      if (pop && is_cmd) begin
         case (w.cmd.opcode)
            rd_inv: begin
               resp.load = 1'b1;
               resp.word = {16'h0000, inv_reg};
            end
            rd_leds: begin
               resp.load = 1'b1;
               resp.word = {16'h0000, leds};
            end
            rd_vec: begin
               resp.load = 1'b1;
               resp.word = {8'h00, vec[0]};
            end
            default: ;
         endcase
      end else if (frame_done && rd_left != '0) begin
         // rest of the vector, one element per frame
         resp.load = 1'b1;
         resp.word = {8'h00, vec[rd_idx]};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_left <= '0;
         rd_left <= '0;
         inv_reg <= '0;
         leds    <= '0;
         for (int i = 0; i < vec_len; i++) begin
            vec[i] <= '0;
         end
      end else begin
         if (frame_done && rd_left != '0) begin
            rd_left <= rd_left - 1'b1;
         end
         if (pop) begin
            if (!is_cmd) begin
               vec[wr_idx] <= w.elem.data;
               wr_left     <= wr_left - 1'b1;
            end else begin
               case (w.cmd.opcode)
                  init: begin
                     wr_left <= '0;
                     rd_left <= '0;
                     inv_reg <= '0;
                     leds    <= '0;
                     for (int i = 0; i < vec_len; i++) begin
                        vec[i] <= '0;
                     end
                  end
                  wr_inv:  inv_reg <= ~w.cmd.payload[15:0];
                  wr_leds: leds <= w.cmd.payload[15:0];
                  wr_vec:  wr_left <= vec_cnt_t'(vec_len);
                  // element 0 goes out now, the rest count down
                  rd_vec:  rd_left <= vec_cnt_t'(vec_len - 1);
                  default: ;
               endcase
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/spi_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_top
   import spi_link_pkg::*, cmd_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        sck,
   input  logic        ss_n,
   input  logic        mosi,
   output logic        miso,
   output logic [15:0] leds
);

   rx_word_t  rx;
   pop_word_t fifo_rd;
   logic      pop;
   logic      frame_done;
   resp_t     resp;

   spi_link spi_link_inst (
      .clk        (clk),
      .reset      (reset),
      .sck        (sck),
      .ss_n       (ss_n),
      .mosi       (mosi),
      .miso       (miso),
      .rx         (rx),
      .frame_done (frame_done),
      .resp       (resp)
   );

   word_fifo word_fifo_inst (
      .clk   (clk),
      .reset (reset),
      .wr    (rx),
      .rd    (fifo_rd),
      .pop   (pop)
   );

   cmd_engine cmd_engine_inst (
      .clk        (clk),
      .reset      (reset),
      .rd         (fifo_rd),
      .pop        (pop),
      .frame_done (frame_done),
      .resp       (resp),
      .leds       (leds)
   );

endmodule

`default_nettype wire

//--- test/tb_spi_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_cmd
   import spi_link_pkg::*, cmd_pkg::*;
;

   // host timing in clk cycles
   localparam int sck_half = 4;
   localparam int gap_clk = 14;
   localparam int frame_clk = 2 * sck_half * frame_bits + sck_half + gap_clk + 2;
   localparam int frames_total = 240;
   localparam int watchdog_ns = (frames_total * frame_clk + 200) * 10;

   logic        clk = 1'b0;
   logic        reset;
   logic        sck;
   logic        ss_n;
   logic        mosi;
   logic        miso;
   logic [15:0] leds;

   logic [15:0] lfsr = 16'd95;
   int          word_errors = 0;
   int          leds_errors = 0;

   // reference model state
   word_t       m_pending;
   logic [15:0] m_leds;
   logic [15:0] m_inv;
   logic [23:0] m_vec [vec_len];
   int          m_wr_left;
   int          m_rd_left;

   spi_cmd_top spi_cmd_top_inst (
      .clk   (clk),
      .reset (reset),
      .sck   (sck),
      .ss_n  (ss_n),
      .mosi  (mosi),
      .miso  (miso),
      .leds  (leds)
   );

   always #5 clk = ~clk;

   // galois lfsr, taps x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic word_t make_cmd(input opcode_t op, input logic [23:0] payload);
      cmd_word_u u;
      u.cmd.opcode = op;
      u.cmd.payload = payload;
      return u;
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         word_errors++;
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_leds(input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         leds_errors++;
         $display("FAIL %0t leds got %h expected %h", $time, got, exp);
      end
   endtask

   task automatic clear_model();
      m_wr_left = 0;
      m_rd_left = 0;
      m_inv = '0;
      m_leds = '0;
      for (int i = 0; i < vec_len; i++) begin
         m_vec[i] = '0;
      end
   endtask

   // end of frame, countdown first and then the popped word
   task automatic model_frame(input word_t f, input bit full);
      cmd_word_u u;
      u = f;
      if (m_rd_left != 0) begin
         m_pending = {8'h00, m_vec[vec_len - m_rd_left]};
         m_rd_left--;
      end
      if (full) begin
         if (m_wr_left != 0) begin
            m_vec[vec_len - m_wr_left] = u.elem.data;
            m_wr_left--;
         end else begin
            case (u.cmd.opcode)
               init:    clear_model();
               wr_inv:  m_inv = ~u.cmd.payload[15:0];
               rd_inv:  m_pending = {16'h0000, m_inv};
               wr_leds: m_leds = u.cmd.payload[15:0];
               rd_leds: m_pending = {16'h0000, m_leds};
               wr_vec:  m_wr_left = vec_len;
               rd_vec: begin
                  m_pending = {8'h00, m_vec[0]};
                  m_rd_left = vec_len - 1;
               end
               default: ;
            endcase
         end
      end
   endtask

   // mode 0 master, miso sampled just before each sck rise
   task automatic send_frame(input word_t f, input int nbits, output word_t got);
      got = '0;
      @(posedge clk);
      ss_n <= 1'b0;
      mosi <= f[frame_bits-1];
      for (int i = 0; i < nbits; i++) begin
         repeat (sck_half - 1) @(posedge clk);
         @(negedge clk);
         got = {got[frame_bits-2:0], miso};
         @(posedge clk);
         sck <= 1'b1;
         repeat (sck_half) @(posedge clk);
         sck <= 1'b0;
         if (i < frame_bits - 1) begin
            mosi <= f[frame_bits-2-i];
         end
      end
      repeat (sck_half) @(posedge clk);
      ss_n <= 1'b1;
      mosi <= 1'b0;
   endtask

   task automatic run_frame(input word_t f, input int nbits);
      word_t exp_miso;
      word_t got_miso;
      exp_miso = m_pending;
      m_pending = '0;
      send_frame(f, nbits, got_miso);
      // a cut frame returns only part of a word
      if (nbits == frame_bits) begin
         check_word("miso", got_miso, exp_miso);
      end
      model_frame(f, nbits == frame_bits);
      repeat (gap_clk) @(posedge clk);
      @(negedge clk);
      check_leds(leds, m_leds);
   endtask

   initial begin
      #(watchdog_ns);
      $display("watchdog timeout, the run did not finish in time");
      $display("Done: errors found");
      $finish;
   end

   initial begin
      int n;
      sck = 1'b0;
      ss_n = 1'b1;
      mosi = 1'b0;
      reset = 1'b1;
      m_pending = '0;
      clear_model();
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      repeat (4) @(posedge clk);

      // idle state after reset
      @(negedge clk);
      check_leds(leds, 16'h0000);
      run_frame(make_cmd(nop, 24'h0), frame_bits);
      run_frame(make_cmd(nop, 24'h0), frame_bits);

      // leds write and readback
      run_frame(make_cmd(wr_leds, 24'(rand_bits(24))), frame_bits);
      run_frame(make_cmd(rd_leds, 24'h0), frame_bits);
      run_frame(make_cmd(nop, 24'h0), frame_bits);

      // inverted register
      run_frame(make_cmd(wr_inv, 24'(rand_bits(24))), frame_bits);
      run_frame(make_cmd(rd_inv, 24'h0), frame_bits);
      run_frame(make_cmd(nop, 24'h0), frame_bits);

      // vector write, then read back over four frames
      run_frame(make_cmd(wr_vec, 24'h0), frame_bits);
      for (int i = 0; i < vec_len; i++) begin
         run_frame(rand_bits(32), frame_bits);
      end
      run_frame(make_cmd(rd_vec, 24'h0), frame_bits);
      for (int i = 0; i < vec_len; i++) begin
         run_frame(make_cmd(nop, 24'h0), frame_bits);
      end

      // cut frame is dropped
      n = int'(rand_bits(5));
      run_frame(make_cmd(wr_leds, 24'(rand_bits(24))), n);
      run_frame(make_cmd(nop, 24'h0), frame_bits);
      run_frame(make_cmd(rd_leds, 24'h0), frame_bits);
      run_frame(make_cmd(nop, 24'h0), frame_bits);

      // init clears everything
      run_frame(make_cmd(init, 24'h0), frame_bits);
      run_frame(make_cmd(rd_inv, 24'h0), frame_bits);
      run_frame(make_cmd(rd_leds, 24'h0), frame_bits);
      run_frame(make_cmd(rd_vec, 24'h0), frame_bits);
      for (int i = 0; i < vec_len; i++) begin
         run_frame(make_cmd(nop, 24'h0), frame_bits);
      end

      // random mix, vector writes turn later frames into elements
      for (int i = 0; i < 200; i++) begin
         run_frame(make_cmd(opcode_t'(8'(rand_bits(3))), 24'(rand_bits(24))), frame_bits);
      end

      $display("errors: %0d word, %0d leds, %0d total", word_errors, leds_errors,
               word_errors + leds_errors);
      if (word_errors + leds_errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
hw/spi_link_pkg.sv
hw/cmd_pkg.sv
hw/spi_link.sv
hw/word_fifo.sv
hw/cmd_engine.sv
hw/spi_cmd_top.sv
test/tb_spi_cmd.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_spi_cmd
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Done: errors found

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	   echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
